// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tcb_mem_tb -f tcb_mem_top.f || exit 1
out=$(./obj_dir/Vtcb_mem_tb +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && echo "simulation ok" || { echo "simulation not ok"; exit 1; }

// ==== sim/tcb_mem_properties.sv ====
`timescale 1ns/1ps

`include "tcb_defines.svh"

module tcb_mem_properties (
  input logic              tcb,
  input logic              rst_n,
  input logic [1:0]        trn,
  input tcb_pkg::tcb_req_t req [2],
  input tcb_pkg::tcb_rsp_t rsp [2],
  input logic [1:0]        rdy
);

  import tcb_pkg::*;

  localparam int unsigned SIZ = `TCB_MEM_SIZ;
  localparam int unsigned BEN = `TCB_BEN;
  localparam int unsigned DLY = `TCB_DLY;

  // failed assertion count
  int unsigned fails = 0;

  // shadow of the storage array
  logic [7:0] shadow [SIZ];

  // expected read data, now and after the delay line
  logic [`TCB_DAT_W-1:0] now [2];
  logic [`TCB_DAT_W-1:0] due [2];

  //////////////////////////////
  // shadow memory
  //////////////////////////////

  // port 0 is the only writer
  always @(posedge tcb) begin
    if (rst_n && trn[0] && req[0].wen) begin
      for (int l = 0; l < BEN; l++) begin
        if (req[0].ben[l])
          shadow[(req[0].adr - req[0].adr % BEN + l) % SIZ] <= req[0].wdt[8*l +: 8];
      end
    end
  end

  // lane rules on the pre-write shadow
  always_comb begin
    now[0] = '0;
    now[1] = '0;
    if (trn[0] && !req[0].wen) begin
      for (int l = 0; l < BEN; l++) begin
        if (req[0].ben[l])
          now[0][8*l +: 8] = shadow[(req[0].adr - req[0].adr % BEN + l) % SIZ];
      end
    end
    if (trn[1] && !req[1].wen) begin
      for (int b = 0; b < (1 << req[1].siz); b++) begin
        now[1][8*b +: 8] = shadow[(req[1].adr + b) % SIZ];
      end
    end
  end

  if (DLY == 0) begin: comb
    assign due[0] = now[0];
    assign due[1] = now[1];
  end: comb
  else begin: pipe
    logic [`TCB_DAT_W-1:0] stg [DLY][2];
    always @(posedge tcb or negedge rst_n) begin
      if (!rst_n) begin
        for (int d = 0; d < DLY; d++) begin
          stg[d][0] <= '0;
          stg[d][1] <= '0;
        end
      end else begin
        stg[0] <= now;
        for (int d = 1; d < DLY; d++) begin
          stg[d] <= stg[d-1];
        end
      end
    end
    assign due[0] = stg[DLY-1][0];
    assign due[1] = stg[DLY-1][1];
  end: pipe

  //////////////////////////////
  // assertions
  //////////////////////////////

  rdy_high: assert property (@(posedge tcb) rdy == 2'b11)
    else begin $error("rdy low"); fails++; end

  sts_zero: assert property (@(posedge tcb) !rsp[0].sts && !rsp[1].sts)
    else begin $error("sts set"); fails++; end

  // read data follows the lane rules after the delay
  rdt_port0: assert property (@(posedge tcb) disable iff (!rst_n) rsp[0].rdt == due[0])
    else begin $error("port 0 rdt %h, shadow gives %h", rsp[0].rdt, due[0]); fails++; end

  rdt_port1: assert property (@(posedge tcb) disable iff (!rst_n) rsp[1].rdt == due[1])
    else begin $error("port 1 rdt %h, shadow gives %h", rsp[1].rdt, due[1]); fails++; end

  rst_clear: assert property (@(posedge tcb) !rst_n |-> rsp[0] == '0 && rsp[1] == '0)
    else begin $error("rsp not clear in reset"); fails++; end

endmodule: tcb_mem_properties

bind tcb_mem_top tcb_mem_properties prop_i (.*);

// ==== sim/tcb_mem_tb.sv ====
`timescale 1ns/1ps

`include "tcb_defines.svh"

module tcb_mem_tb;

  import tcb_pkg::*;

  localparam int unsigned SIZ = `TCB_MEM_SIZ;
  localparam int unsigned BEN = `TCB_BEN;
  localparam int unsigned DLY = `TCB_DLY;
  // cycles allowed for pending responses to drain
  localparam int unsigned TMO = DLY + 20;

  // expected read data and the cycle it shows on rsp
  typedef struct packed {
    logic [31:0]           due;
    logic [`TCB_DAT_W-1:0] rdt;
  } exp_t;

  logic       tcb;
  logic       rst_n;
  logic [1:0] trn;
  tcb_req_t   req [2];
  tcb_rsp_t   rsp [2];
  logic [1:0] rdy;

  // reference byte memory following port 0 writes
  logic [7:0]  ref_mem [SIZ];
  exp_t        pend [2][$];
  logic [31:0] cyc;
  logic [31:0] rng;
  int unsigned errs;
  int unsigned tests;
  int unsigned bad_tests;

  tcb_mem_top dut_i (
    .tcb   (tcb),
    .rst_n (rst_n),
    .trn   (trn),
    .req   (req),
    .rsp   (rsp),
    .rdy   (rdy)
  );

  // 100 ns period
  always #50 tcb = ~tcb;

  always @(posedge tcb) begin
    cyc <= cyc + 1;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // initial content from every address bit
  function automatic logic [7:0] fill_byte(input int unsigned a);
    int unsigned x;
    x = a % SIZ;
    return 8'((x ^ (x >> 8) * 77) & 255);
  endfunction

  // byte enable read with lanes relative to the word base
  function automatic logic [`TCB_DAT_W-1:0] ben_read(input logic [31:0] adr,
                                                      input logic [BEN-1:0] ben);
    logic [`TCB_DAT_W-1:0] d;
    d = '0;
    for (int l = 0; l < BEN; l++) begin
      if (ben[l])
        d[8*l +: 8] = ref_mem[(adr - adr % BEN + l) % SIZ];
    end
    return d;
  endfunction

  // log size read low aligned from adr onward
  function automatic logic [`TCB_DAT_W-1:0] log_read(input logic [31:0] adr,
                                                      input logic [1:0] siz);
    logic [`TCB_DAT_W-1:0] d;
    d = '0;
    for (int b = 0; b < (1 << siz); b++) begin
      d[8*b +: 8] = ref_mem[(adr + b) % SIZ];
    end
    return d;
  endfunction

  function automatic tcb_req_t mk_req(input logic wen, input logic [31:0] adr,
                                      input logic [1:0] siz, input logic [BEN-1:0] ben,
                                      input logic [`TCB_DAT_W-1:0] wdt);
    tcb_req_t r;
    r.wen = wen;
    r.adr = adr;
    r.siz = siz;
    r.ben = ben;
    r.wdt = wdt;
    return r;
  endfunction

  //////////////////////////////
  // driving and checking
  //////////////////////////////

  // one bus cycle on both ports
  // reads see memory before this cycle's write
  task automatic cycle(input logic t0, input tcb_req_t r0, input logic t1, input tcb_req_t r1);
    exp_t e;
    @(posedge tcb);
    trn    <= {t1, t0};
    req[0] <= r0;
    req[1] <= r1;
    e.due = cyc + 1 + DLY;
    if (t0) begin
      e.rdt = r0.wen ? '0 : ben_read(r0.adr, r0.ben);
      pend[0].push_back(e);
    end
    if (t1) begin
      e.rdt = r1.wen ? '0 : log_read(r1.adr, r1.siz);
      pend[1].push_back(e);
    end
    // only port 0 can change memory
    if (t0 && r0.wen) begin
      for (int l = 0; l < BEN; l++) begin
        if (r0.ben[l])
          ref_mem[(r0.adr - r0.adr % BEN + l) % SIZ] = r0.wdt[8*l +: 8];
      end
    end
  endtask

  // reset while a read response sits in the delay line
  // the response is dropped and memory keeps its contents
  task automatic reset_during_read(input logic [31:0] adr);
    @(posedge tcb);
    trn    <= 2'b01;
    req[0] <= mk_req(1'b0, adr, 2'd2, '1, '0);
    @(posedge tcb);
    trn   <= '0;
    rst_n <= 1'b0;
    repeat (2) @(posedge tcb);
    rst_n <= 1'b1;
  endtask

  // idle the bus and wait for every expected response
  task automatic drain();
    int unsigned n;
    n = 0;
    @(posedge tcb);
    trn <= '0;
    while ((pend[0].size() != 0 || pend[1].size() != 0) && n < TMO) begin
      @(posedge tcb);
      n++;
    end
    if (n >= TMO) begin
      $display("responses still missing %0d cycles after the last request, at %0t ns",
               TMO, $time);
      errs++;
    end
  endtask

  task automatic finish_test(input string name, input int unsigned errs_before);
    drain();
    tests++;
    if (errs == errs_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      bad_tests++;
      $display("test %0d %s: %0d errors", tests, name, errs - errs_before);
    end
  endtask

  // compare each port's due response every cycle out of reset
  always @(posedge tcb) begin
    exp_t e;
    if (rst_n) begin
      if (rdy !== 2'b11) begin
        $display("Error at %0t ns: rdy expected 11 got %b", $time, rdy);
        errs++;
      end
      for (int p = 0; p < 2; p++) begin
        if (rsp[p].sts !== 1'b0) begin
          $display("Error at %0t ns: rsp[%0d].sts expected 0 got %b", $time, p, rsp[p].sts);
          errs++;
        end
        if (pend[p].size() != 0 && pend[p][0].due == cyc) begin
          e = pend[p].pop_front();
          if (rsp[p].rdt !== e.rdt) begin
            $display("Error at %0t ns: rsp[%0d].rdt expected %h got %h",
                     $time, p, e.rdt, rsp[p].rdt);
            errs++;
          end
        end
      end
    end
  end

  //////////////////////////////
  // tests
  //////////////////////////////

  initial begin
    int unsigned          e0;
    logic [31:0]          a;
    logic [31:0]          hi;
    logic [`TCB_DAT_W-1:0] d;
    logic [31:0]          adrs [8];
    logic [BEN-1:0]       b;
    logic [1:0]           s;
    tcb_req_t             idle;
    tcb     = 1'b0;
    rst_n   = 1'b0;
    trn     = '0;
    req[0]  = '0;
    req[1]  = '0;
    cyc     = '0;
    rng     = 32'd22138;
    errs    = 0;
    tests   = 0;
    bad_tests = 0;
    idle    = '0;
    repeat (2) @(posedge tcb);
    rst_n <= 1'b1;

    // whole memory gets a known pattern first
    e0 = errs;
    for (int unsigned w = 0; w < SIZ / BEN; w++) begin
      for (int l = 0; l < BEN; l++) begin
        d[8*l +: 8] = fill_byte(w * BEN + l);
      end
      cycle(1'b1, mk_req(1'b1, w * BEN, 2'd2, '1, d), 1'b0, idle);
    end
    finish_test("fill", e0);

    // full words at random aligned addresses
    e0 = errs;
    for (int i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      adrs[i] = rng & (SIZ - BEN);
      rng = xorshift(rng);
      cycle(1'b1, mk_req(1'b1, adrs[i], 2'd2, '1, rng), 1'b0, idle);
    end
    for (int i = 0; i < 8; i++) begin
      cycle(1'b1, mk_req(1'b0, adrs[i], 2'd2, '1, '0), 1'b0, idle);
    end
    finish_test("full word write and read", e0);

    // partial writes then full and masked reads
    e0 = errs;
    for (int i = 0; i < 6; i++) begin
      rng = xorshift(rng);
      a = rng & (SIZ - BEN);
      b = rng[BEN+11:12];
      if (&b)
        b[0] = 1'b0;
      rng = xorshift(rng);
      cycle(1'b1, mk_req(1'b1, a, 2'd2, b, rng), 1'b0, idle);
      cycle(1'b1, mk_req(1'b0, a, 2'd2, '1, '0), 1'b0, idle);
      cycle(1'b1, mk_req(1'b0, a, 2'd2, b, '0), 1'b0, idle);
    end
    finish_test("byte enable write", e0);

    // 1, 2 and 4 byte reads at every aligned offset
    e0 = errs;
    rng = xorshift(rng);
    a = rng & (SIZ - BEN);
    for (int z = 0; z < 3; z++) begin
      for (int o = 0; o < BEN; o += (1 << z)) begin
        cycle(1'b0, idle, 1'b1, mk_req(1'b0, a + o, 2'(z), '0, '0));
      end
    end
    finish_test("log size read", e0);

    // port 1 is read only
    e0 = errs;
    rng = xorshift(rng);
    a = rng & (SIZ - BEN);
    cycle(1'b0, idle, 1'b1, mk_req(1'b1, a, 2'd2, '1, ~ben_read(a, '1)));
    cycle(1'b1, mk_req(1'b0, a, 2'd2, '1, '0), 1'b0, idle);
    finish_test("port 1 write ignored", e0);

    // both ports with one read per cycle and no gaps
    e0 = errs;
    for (int i = 0; i < 32; i++) begin
      rng = xorshift(rng);
      a = rng;
      rng = xorshift(rng);
      s = (rng[1:0] == 2'd3) ? 2'd2 : rng[1:0];
      hi = rng & ~((32'd1 << s) - 1);
      cycle(1'b1, mk_req(1'b0, a, 2'd2, a[BEN+7:8], '0),
            1'b1, mk_req(1'b0, hi, s, '0, '0));
    end
    finish_test("back to back reads", e0);

    // high addresses wrap onto the memory
    e0 = errs;
    for (int i = 0; i < 4; i++) begin
      rng = xorshift(rng);
      a = rng & (SIZ - BEN);
      rng = xorshift(rng);
      hi = (rng & ~(SIZ - 1)) | a | SIZ;
      rng = xorshift(rng);
      cycle(1'b1, mk_req(1'b1, hi, 2'd2, '1, rng), 1'b0, idle);
      cycle(1'b1, mk_req(1'b0, a, 2'd2, '1, '0),
            1'b1, mk_req(1'b0, hi + 1, 2'd0, '0, '0));
    end
    finish_test("address wrap", e0);

    // known word, then reset with its read in flight
    e0 = errs;
    rng = xorshift(rng);
    a = rng & (SIZ - BEN);
    cycle(1'b1, mk_req(1'b1, a, 2'd2, '1, 32'ha5c3_0ff0), 1'b0, idle);
    reset_during_read(a);
    cycle(1'b1, mk_req(1'b0, a, 2'd2, '1, '0), 1'b0, idle);
    finish_test("reset with read in flight", e0);

    $display("tests %0d, failing tests %0d, errors %0d, assertion failures %0d",
             tests, bad_tests, errs, dut_i.prop_i.fails);
    if (errs == 0 && dut_i.prop_i.fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule: tcb_mem_tb

// ==== source/tcb_defines.svh ====
`ifndef TCB_DEFINES_SVH
`define TCB_DEFINES_SVH

//////////////////////////////
// bus geometry
//////////////////////////////

// byte address width
`define TCB_ADR_W 32

// data width and its byte count
`define TCB_DAT_W 32
`define TCB_BEN (`TCB_DAT_W/8)

//////////////////////////////
// memory geometry
//////////////////////////////

// memory size in bytes, power of two
`define TCB_MEM_SIZ 1024

// word index width into the byte banks
`define TCB_WAD_W ($clog2(`TCB_MEM_SIZ) - $clog2(`TCB_BEN))

// read data latency in cycles, 0 means combinational
`define TCB_DLY 1

`endif

// ==== source/tcb_mem_array.sv ====
`timescale 1ns/1ps

`include "tcb_defines.svh"

module tcb_mem_array #(
  // write mask, one bit per port
  parameter logic [1:0]  WRM = 2'b01,
  // size in bytes
  parameter int unsigned SIZ = `TCB_MEM_SIZ
)(
  input  logic                  tcb,
  input  logic                  rst_n,
  // decoded access per port
  input  tcb_pkg::tcb_lane_t    lane [2],
  // raw word per port, memory lane order
  output logic [`TCB_DAT_W-1:0] rdat [2]
);

  //////////////////////////////
  // geometry
  //////////////////////////////

  localparam int unsigned BEN = `TCB_BEN;
  localparam int unsigned DEP = SIZ / BEN;

  // one byte bank per lane
  logic [7:0] mem [BEN][DEP];

  // word index per port, wrapped to bank depth
  int unsigned widx [2];

  always_comb begin
    for (int unsigned p = 0; p < 2; p++) begin
      widx[p] = int'(lane[p].wadr) % DEP;
    end
  end

  //////////////////////////////
  // write
  //////////////////////////////

  // banks carry no reset
  // bus is ignored while held in reset so contents survive
  always_ff @(posedge tcb) begin
    if (rst_n) begin
      for (int unsigned l = 0; l < BEN; l++) begin
        // higher index first, later assignment wins
        // so the lower port takes a shared byte
        for (int p = 1; p >= 0; p--) begin
          if (WRM[p] && lane[p].wen && lane[p].ben[l]) begin
            mem[l][widx[p]] <= lane[p].dat[8*l +: 8];
          end
        end
      end
    end
  end

  //////////////////////////////
  // read
  //////////////////////////////

  // whole word per port, every cycle
  // lane selection and zeroing are left to the decoder
  always_comb begin
    for (int unsigned p = 0; p < 2; p++) begin
      for (int unsigned l = 0; l < BEN; l++) begin
        rdat[p][8*l +: 8] = mem[l][widx[p]];
      end
    end
  end

endmodule: tcb_mem_array

// ==== source/tcb_mem_port.sv ====
`timescale 1ns/1ps

`include "tcb_defines.svh"

module tcb_mem_port #(
  // transfer size mode of this port
  parameter tcb_pkg::tcb_mode_e MOD = tcb_pkg::TCB_BYTE_ENA
)(
  // bus side
  input  logic                  trn,
  input  tcb_pkg::tcb_req_t     req,
  // array side
  output tcb_pkg::tcb_lane_t    lane,
  input  logic [`TCB_DAT_W-1:0] rdat,
  // undelayed response
  output tcb_pkg::tcb_rsp_t     raw
);

  import tcb_pkg::*;

  //////////////////////////////
  // local signals
  //////////////////////////////

  localparam int unsigned BEN = `TCB_BEN;
  localparam int unsigned OFW = $clog2(BEN);

  // byte offset inside the word
  logic [OFW-1:0] off;

  // lanes touched, bus order
  logic [BEN-1:0] acc;
  // lanes touched, memory order
  logic [BEN-1:0] ena;

  // byte views of the data paths
  logic [BEN-1:0][7:0] wbus;
  logic [BEN-1:0][7:0] wmem;
  logic [BEN-1:0][7:0] rmem;
  logic [BEN-1:0][7:0] rbus;

  // read transfer this cycle
  logic rd;

  assign off  = req.adr[OFW-1:0];
  assign wbus = req.wdt;
  assign rmem = rdat;
  assign rd   = trn & ~req.wen;

  //////////////////////////////
  // lane decode
  //////////////////////////////

  always_comb begin
    acc = '0;
    ena = '0;
    if (MOD == TCB_BYTE_ENA) begin
      // enables already sit on memory lanes
      acc = req.ben;
      ena = req.ben;
    end else begin
      // low 2**siz bus lanes
      for (int unsigned b = 0; b < BEN; b++) begin
        acc[b] = (b < (32'd1 << req.siz));
      end
      // bus byte b lands on memory lane off+b
      // word crossing is not supported, so wrap within the word
      for (int unsigned b = 0; b < BEN; b++) begin
        ena[(off + b) % BEN] = acc[b];
      end
    end
  end

  //////////////////////////////
  // data rotation
  //////////////////////////////

  // write data into memory lanes
  always_comb begin
    wmem = wbus;
    if (MOD == TCB_LOG_SIZE) begin
      for (int unsigned b = 0; b < BEN; b++) begin
        wmem[(off + b) % BEN] = wbus[b];
      end
    end
  end

  // read data back to bus lanes
  // untouched lanes read as zero
  always_comb begin
    rbus = '0;
    for (int unsigned b = 0; b < BEN; b++) begin
      if (acc[b]) begin
        if (MOD == TCB_LOG_SIZE) begin
          rbus[b] = rmem[(off + b) % BEN];
        end else begin
          rbus[b] = rmem[b];
        end
      end
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  // word index wraps at memory size
  assign lane.wadr = req.adr[OFW +: `TCB_WAD_W];
  assign lane.ben  = trn ? ena : '0;
  assign lane.wen  = trn & req.wen;
  assign lane.dat  = wmem;

  // writes and idle cycles return zero
  assign raw.rdt = rd ? rbus : '0;
  assign raw.sts = 1'b0;

endmodule: tcb_mem_port

// ==== source/tcb_mem_top.sv ====
`timescale 1ns/1ps

`include "tcb_defines.svh"

module tcb_mem_top (
  input  logic              tcb,
  input  logic              rst_n,
  // subordinate ports
  input  logic [1:0]        trn,
  input  tcb_pkg::tcb_req_t req [2],
  output tcb_pkg::tcb_rsp_t rsp [2],
  output logic [1:0]        rdy
);

  import tcb_pkg::*;

  //////////////////////////////
  // local signals
  //////////////////////////////

  // decoder to array
  tcb_lane_t             lane [2];
  // array to decoder
  logic [`TCB_DAT_W-1:0] rdat [2];
  // decoder to delay line
  tcb_rsp_t              raw  [2];

  // never any back-pressure
  assign rdy = 2'b11;

  //////////////////////////////
  // port decoders
  //////////////////////////////

  // port 0, byte enables, writable
  tcb_mem_port #(
    .MOD  (TCB_BYTE_ENA)
  ) port0_i (
    .trn  (trn[0]),
    .req  (req[0]),
    .lane (lane[0]),
    .rdat (rdat[0]),
    .raw  (raw[0])
  );

  // port 1, log size, read only
  tcb_mem_port #(
    .MOD  (TCB_LOG_SIZE)
  ) port1_i (
    .trn  (trn[1]),
    .req  (req[1]),
    .lane (lane[1]),
    .rdat (rdat[1]),
    .raw  (raw[1])
  );

  //////////////////////////////
  // storage
  //////////////////////////////

  // only port 0 may write
  tcb_mem_array #(
    .WRM   (2'b01),
    .SIZ   (`TCB_MEM_SIZ)
  ) array_i (
    .tcb   (tcb),
    .rst_n (rst_n),
    .lane  (lane),
    .rdat  (rdat)
  );

  //////////////////////////////
  // read latency
  //////////////////////////////

  for (genvar i = 0; i < 2; i++) begin: dly
    tcb_rsp_delay #(
      .DLY   (`TCB_DLY)
    ) delay_i (
      .tcb   (tcb),
      .rst_n (rst_n),
      .din   (raw[i]),
      .dout  (rsp[i])
    );
  end: dly

endmodule: tcb_mem_top

// ==== source/tcb_pkg.sv ====
`include "tcb_defines.svh"

package tcb_pkg;

  //////////////////////////////
  // transfer size encoding
  //////////////////////////////

  // how a request names its bytes
  typedef enum logic {
    TCB_LOG_SIZE,  // 2**siz bytes from adr onward
    TCB_BYTE_ENA   // lanes picked by ben
  } tcb_mode_e;

  //////////////////////////////
  // bus payloads
  //////////////////////////////

  // request from the manager
  typedef struct packed {
    logic                  wen;  // write enable
    logic [`TCB_ADR_W-1:0] adr;  // byte address
    logic [1:0]            siz;  // log2 of transfer size
    logic [`TCB_BEN-1:0]   ben;  // byte enables
    logic [`TCB_DAT_W-1:0] wdt;  // write data
  } tcb_req_t;

  // response to the manager
  typedef struct packed {
    logic [`TCB_DAT_W-1:0] rdt;  // read data
    logic                  sts;  // status, always clear
  } tcb_rsp_t;

  //////////////////////////////
  // decoder to array
  //////////////////////////////

  // one port's access, already in memory lane order
  typedef struct packed {
    logic [`TCB_WAD_W-1:0] wadr;  // word index
    logic [`TCB_BEN-1:0]   ben;   // lane enables
    logic                  wen;   // write this cycle
    logic [`TCB_DAT_W-1:0] dat;   // write data per lane
  } tcb_lane_t;

endpackage: tcb_pkg

// ==== source/tcb_rsp_delay.sv ====
`timescale 1ns/1ps

module tcb_rsp_delay #(
  // number of register stages
  parameter int unsigned DLY = 1
)(
  input  logic              tcb,
  input  logic              rst_n,
  input  tcb_pkg::tcb_rsp_t din,
  output tcb_pkg::tcb_rsp_t dout
);

  import tcb_pkg::*;

  if (DLY == 0) begin: comb

    // no latency, response follows the request
    assign dout = din;

  end: comb
  else begin: pipe

    // stage 0 is closest to the input
    tcb_rsp_t stg [DLY];

    // free running shift, no stall
    always_ff @(posedge tcb or negedge rst_n) begin
      if (!rst_n) begin
        for (int unsigned d = 0; d < DLY; d++) begin
          stg[d] <= '0;
        end
      end else begin
        stg[0] <= din;
        for (int unsigned d = 1; d < DLY; d++) begin
          stg[d] <= stg[d-1];
        end
      end
    end

    assign dout = stg[DLY-1];

  end: pipe

endmodule: tcb_rsp_delay

// ==== tcb_mem_top.f ====
+incdir+source
source/tcb_pkg.sv
source/tcb_mem_array.sv
source/tcb_mem_port.sv
source/tcb_rsp_delay.sv
source/tcb_mem_top.sv
sim/tcb_mem_properties.sv
sim/tcb_mem_tb.sv
